//--- lc4_pkg.sv
package lc4_pkg;

  localparam int WORD_W = 16;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [2:0]        reg_sel_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_CONST,
    ALU_ADDR  // base plus offset, also used by add immediate
  } alu_op_t;

  // stall codes as seen at writeback
  typedef enum logic [1:0] {
    STALL_NONE        = 2'd0,
    STALL_SUPERSCALAR = 2'd1,
    STALL_BUBBLE      = 2'd2,  // left behind by reset
    STALL_LOAD_USE    = 2'd3
  } stall_t;

  // opcodes, insn[15:12]
  localparam logic [3:0] OP_NOP   = 4'h0;
  localparam logic [3:0] OP_ARITH = 4'h1;
  localparam logic [3:0] OP_LOGIC = 4'h5;
  localparam logic [3:0] OP_LDR   = 4'h6;
  localparam logic [3:0] OP_STR   = 4'h7;
  localparam logic [3:0] OP_CONST = 4'h9;

endpackage

//--- lc4_decoder.sv
`timescale 1ns/1ns

module lc4_decoder (
  input  lc4_pkg::word_t    i_insn,
  output lc4_pkg::reg_sel_t o_rs,
  output lc4_pkg::reg_sel_t o_rt,
  output lc4_pkg::reg_sel_t o_rd,
  output logic              o_rs_re,
  output logic              o_rt_re,
  output logic              o_rd_we,
  output logic              o_is_load,
  output logic              o_is_store,
  output lc4_pkg::alu_op_t  o_alu_op,
  output lc4_pkg::word_t    o_imm
);
  import lc4_pkg::*;

  always_comb begin
    o_rs       = i_insn[8:6];
    o_rt       = i_insn[2:0];
    o_rd       = i_insn[11:9];
    o_rs_re    = 1'b0;
    o_rt_re    = 1'b0;
    o_rd_we    = 1'b0;
    o_is_load  = 1'b0;
    o_is_store = 1'b0;
    o_alu_op   = ALU_ADD;
    o_imm      = {{11{i_insn[4]}}, i_insn[4:0]};  // imm5
    case (i_insn[15:12])
      OP_NOP: ;  // branches fall in here too and do nothing
      OP_ARITH: begin
        if (i_insn[5]) begin  // add immediate
          o_rs_re  = 1'b1;
          o_rd_we  = 1'b1;
          o_alu_op = ALU_ADDR;
        end else if (i_insn[5:3] == 3'b000 || i_insn[5:3] == 3'b010) begin
          o_rs_re  = 1'b1;
          o_rt_re  = 1'b1;
          o_rd_we  = 1'b1;
          o_alu_op = i_insn[4] ? ALU_SUB : ALU_ADD;
        end
      end
      OP_LOGIC: begin
        if (i_insn[5:3] == 3'b000) begin  // only register AND is kept
          o_rs_re  = 1'b1;
          o_rt_re  = 1'b1;
          o_rd_we  = 1'b1;
          o_alu_op = ALU_AND;
        end
      end
      OP_LDR: begin
        o_rs_re   = 1'b1;
        o_rd_we   = 1'b1;
        o_is_load = 1'b1;
        o_alu_op  = ALU_ADDR;
        o_imm     = {{10{i_insn[5]}}, i_insn[5:0]};
      end
      OP_STR: begin
        o_rt       = i_insn[11:9];  // store data register
        o_rs_re    = 1'b1;
        o_rt_re    = 1'b1;
        o_is_store = 1'b1;
        o_alu_op   = ALU_ADDR;
        o_imm      = {{10{i_insn[5]}}, i_insn[5:0]};
      end
      OP_CONST: begin
        o_rd_we  = 1'b1;
        o_alu_op = ALU_CONST;
        o_imm    = {{7{i_insn[8]}}, i_insn[8:0]};
      end
      default: ;  // unsupported, all enables stay low
    endcase
  end

endmodule

//--- lc4_alu.sv
`timescale 1ns/1ns

module lc4_alu (
  input  lc4_pkg::alu_op_t i_op,
  input  lc4_pkg::word_t   i_a,
  input  lc4_pkg::word_t   i_b,
  input  lc4_pkg::word_t   i_imm,
  output lc4_pkg::word_t   o_result
);
  import lc4_pkg::*;

  always_comb begin
    case (i_op)
      ALU_ADD:   o_result = i_a + i_b;
      ALU_SUB:   o_result = i_a - i_b;
      ALU_AND:   o_result = i_a & i_b;
      ALU_CONST: o_result = i_imm;
      ALU_ADDR:  o_result = i_a + i_imm;  // ldr/str address and add immediate
      default:   o_result = i_a + i_imm;
    endcase
  end

endmodule

//--- lc4_regfile_2w.sv
`timescale 1ns/1ns

module lc4_regfile_2w (
  input  logic              gwe,
  input  logic              i_rst,
  input  lc4_pkg::reg_sel_t i_rsel_a0,
  input  lc4_pkg::reg_sel_t i_rsel_a1,
  input  lc4_pkg::reg_sel_t i_rsel_b0,
  input  lc4_pkg::reg_sel_t i_rsel_b1,
  input  logic              i_we_a,
  input  logic              i_we_b,
  input  lc4_pkg::reg_sel_t i_wsel_a,
  input  lc4_pkg::reg_sel_t i_wsel_b,
  input  lc4_pkg::word_t    i_wdata_a,
  input  lc4_pkg::word_t    i_wdata_b,
  output lc4_pkg::word_t    o_rdata_a0,
  output lc4_pkg::word_t    o_rdata_a1,
  output lc4_pkg::word_t    o_rdata_b0,
  output lc4_pkg::word_t    o_rdata_b1
);
  import lc4_pkg::*;

  word_t regs [8];
  word_t next_regs [8];  // register state after this cycle's writes

  // lane b is younger, so its write lands last
  always_comb begin
    next_regs = regs;
    if (i_we_a) next_regs[i_wsel_a] = i_wdata_a;
    if (i_we_b) next_regs[i_wsel_b] = i_wdata_b;
  end

  always_ff @(posedge gwe) begin
    if (i_rst) regs <= '{default: '0};
    else       regs <= next_regs;
  end

  // reads see the value being written this cycle
  assign o_rdata_a0 = next_regs[i_rsel_a0];
  assign o_rdata_a1 = next_regs[i_rsel_a1];
  assign o_rdata_b0 = next_regs[i_rsel_b0];
  assign o_rdata_b1 = next_regs[i_rsel_b1];

endmodule

//--- lc4_issue_ctrl.sv
`timescale 1ns/1ns

module lc4_issue_ctrl #(
  parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
  input  logic              gwe,
  input  logic              i_rst,
  input  lc4_pkg::word_t    i_insn_a,
  input  lc4_pkg::word_t    i_insn_b,
  output lc4_pkg::word_t    o_pc,
  output lc4_pkg::reg_sel_t o_rsel_a0, o_rsel_a1, o_rsel_b0, o_rsel_b1,
  input  lc4_pkg::word_t    i_rdata_a0, i_rdata_a1, i_rdata_b0, i_rdata_b1,
  input  logic              i_x_load_a,
  input  lc4_pkg::reg_sel_t i_x_rd_a,
  input  logic              i_x_load_b,
  input  lc4_pkg::reg_sel_t i_x_rd_b,
  // lane a
  output logic              o_issue_a,
  output lc4_pkg::stall_t   o_stall_a,
  output lc4_pkg::reg_sel_t o_rd_a, o_rs_a, o_rt_a,
  output logic              o_rd_we_a, o_is_load_a, o_is_store_a,
  output lc4_pkg::alu_op_t  o_alu_op_a,
  output lc4_pkg::word_t    o_imm_a, o_a_a, o_b_a,
  // lane b
  output logic              o_issue_b,
  output lc4_pkg::stall_t   o_stall_b,
  output lc4_pkg::reg_sel_t o_rd_b, o_rs_b, o_rt_b,
  output logic              o_rd_we_b, o_is_load_b, o_is_store_b,
  output lc4_pkg::alu_op_t  o_alu_op_b,
  output lc4_pkg::word_t    o_imm_b, o_a_b, o_b_b
);
  import lc4_pkg::*;

  logic rs_re_a, rt_re_a, rs_re_b, rt_re_b;
  logic ldu_a, ldu_b, dep_b_on_a, mem_pair;

  function automatic logic uses(input logic rs_re, input reg_sel_t rs,
                                input logic rt_re, input reg_sel_t rt, input reg_sel_t r);
    return (rs_re && rs == r) || (rt_re && rt == r);
  endfunction

  lc4_decoder dec_a (
    .i_insn(i_insn_a), .o_rs(o_rs_a), .o_rt(o_rt_a), .o_rd(o_rd_a),
    .o_rs_re(rs_re_a), .o_rt_re(rt_re_a), .o_rd_we(o_rd_we_a),
    .o_is_load(o_is_load_a), .o_is_store(o_is_store_a),
    .o_alu_op(o_alu_op_a), .o_imm(o_imm_a)
  );

  lc4_decoder dec_b (
    .i_insn(i_insn_b), .o_rs(o_rs_b), .o_rt(o_rt_b), .o_rd(o_rd_b),
    .o_rs_re(rs_re_b), .o_rt_re(rt_re_b), .o_rd_we(o_rd_we_b),
    .o_is_load(o_is_load_b), .o_is_store(o_is_store_b),
    .o_alu_op(o_alu_op_b), .o_imm(o_imm_b)
  );

  assign o_rsel_a0 = o_rs_a;
  assign o_rsel_a1 = o_rt_a;
  assign o_rsel_b0 = o_rs_b;
  assign o_rsel_b1 = o_rt_b;
  assign o_a_a     = i_rdata_a0;
  assign o_b_a     = i_rdata_a1;
  assign o_a_b     = i_rdata_b0;
  assign o_b_b     = i_rdata_b1;

  // a load in x of either lane cannot forward in time
  assign ldu_a = (i_x_load_a && uses(rs_re_a, o_rs_a, rt_re_a, o_rt_a, i_x_rd_a)) ||
                 (i_x_load_b && uses(rs_re_a, o_rs_a, rt_re_a, o_rt_a, i_x_rd_b));
  assign ldu_b = (i_x_load_a && uses(rs_re_b, o_rs_b, rt_re_b, o_rt_b, i_x_rd_a)) ||
                 (i_x_load_b && uses(rs_re_b, o_rs_b, rt_re_b, o_rt_b, i_x_rd_b));

  assign dep_b_on_a = o_rd_we_a && uses(rs_re_b, o_rs_b, rt_re_b, o_rt_b, o_rd_a);
  assign mem_pair   = (o_is_load_a || o_is_store_a) && (o_is_load_b || o_is_store_b);

  always_comb begin
    o_issue_a = 1'b1;
    o_issue_b = 1'b1;
    o_stall_a = STALL_NONE;
    o_stall_b = STALL_NONE;
    if (ldu_a) begin  // whole pair waits
      o_issue_a = 1'b0;
      o_issue_b = 1'b0;
      o_stall_a = STALL_LOAD_USE;
      o_stall_b = STALL_SUPERSCALAR;
    end else if (ldu_b) begin
      o_issue_b = 1'b0;
      o_stall_b = STALL_LOAD_USE;
    end else if (dep_b_on_a || mem_pair) begin  // split, b goes next cycle as a
      o_issue_b = 1'b0;
      o_stall_b = STALL_SUPERSCALAR;
    end
  end

  always_ff @(posedge gwe) begin
    if (i_rst)          o_pc <= RESET_PC;
    else if (o_issue_b) o_pc <= o_pc + 16'd2;
    else if (o_issue_a) o_pc <= o_pc + 16'd1;
  end

endmodule

//--- lc4_lane.sv
`timescale 1ns/1ns

module lc4_lane #(
  parameter bit IS_SECOND = 1'b0  // 1 for lane b, the younger of a pair
) (
  input  logic              gwe,
  input  logic              i_rst,
  input  logic              i_issue,
  input  lc4_pkg::stall_t   i_stall,
  input  lc4_pkg::reg_sel_t i_rd, i_rs, i_rt,
  input  logic              i_rd_we, i_is_load, i_is_store,
  input  lc4_pkg::alu_op_t  i_alu_op,
  input  lc4_pkg::word_t    i_imm, i_a, i_b,
  output logic              o_x_load,
  output lc4_pkg::reg_sel_t o_x_rd,
  output logic              o_m_we,
  output lc4_pkg::reg_sel_t o_m_rd,
  output lc4_pkg::word_t    o_m_result,
  input  logic              i_peer_m_we,
  input  lc4_pkg::reg_sel_t i_peer_m_rd,
  input  lc4_pkg::word_t    i_peer_m_result,
  output logic              o_w_we,
  output lc4_pkg::reg_sel_t o_w_rd,
  output lc4_pkg::word_t    o_w_data,
  output lc4_pkg::stall_t   o_w_stall,
  input  logic              i_peer_w_we,
  input  lc4_pkg::reg_sel_t i_peer_w_rd,
  input  lc4_pkg::word_t    i_peer_w_data,
  output logic              o_mem_rd, o_mem_wr,
  output lc4_pkg::word_t    o_mem_addr, o_mem_wdata,
  input  lc4_pkg::word_t    i_mem_rdata
);
  import lc4_pkg::*;

  logic     x_rd_we, x_is_load, x_is_store;
  stall_t   x_stall;
  reg_sel_t x_rd, x_rs, x_rt;
  alu_op_t  x_alu_op;
  word_t    x_imm, x_a, x_b;
  word_t    op_a, op_b, alu_result;

  logic     m_rd_we, m_is_load, m_is_store;
  stall_t   m_stall;
  reg_sel_t m_rd;
  word_t    m_result, m_b;

  logic     w_rd_we;
  stall_t   w_stall;
  reg_sel_t w_rd;
  word_t    w_data;

  // bypass sources, index 0 is the youngest producer
  logic     src_we [4];
  reg_sel_t src_rd [4];
  word_t    src_data [4];

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      x_rd_we    <= 1'b0;
      x_is_load  <= 1'b0;
      x_is_store <= 1'b0;
      x_stall    <= STALL_BUBBLE;
      m_rd_we    <= 1'b0;
      m_is_load  <= 1'b0;
      m_is_store <= 1'b0;
      m_stall    <= STALL_BUBBLE;
      w_rd_we    <= 1'b0;
      w_stall    <= STALL_BUBBLE;
    end else begin
      x_rd_we    <= i_issue && i_rd_we;  // no issue loads a bubble
      x_is_load  <= i_issue && i_is_load;
      x_is_store <= i_issue && i_is_store;
      x_stall    <= i_issue ? STALL_NONE : i_stall;
      m_rd_we    <= x_rd_we;
      m_is_load  <= x_is_load;
      m_is_store <= x_is_store;
      m_stall    <= x_stall;
      w_rd_we    <= m_rd_we;
      w_stall    <= m_stall;
    end
  end

  always_ff @(posedge gwe) begin
    x_rd     <= i_rd;
    x_rs     <= i_rs;
    x_rt     <= i_rt;
    x_alu_op <= i_alu_op;
    x_imm    <= i_imm;
    x_a      <= i_a;
    x_b      <= i_b;
    m_rd     <= x_rd;
    m_result <= alu_result;
    m_b      <= op_b;  // store data, already bypassed
    w_rd     <= m_rd;
    w_data   <= m_is_load ? i_mem_rdata : m_result;
  end

  // within a stage lane b is younger, and m is younger than w
  assign src_we[0]   = IS_SECOND ? m_rd_we : i_peer_m_we;
  assign src_rd[0]   = IS_SECOND ? m_rd : i_peer_m_rd;
  assign src_data[0] = IS_SECOND ? m_result : i_peer_m_result;
  assign src_we[1]   = IS_SECOND ? i_peer_m_we : m_rd_we;
  assign src_rd[1]   = IS_SECOND ? i_peer_m_rd : m_rd;
  assign src_data[1] = IS_SECOND ? i_peer_m_result : m_result;
  assign src_we[2]   = IS_SECOND ? w_rd_we : i_peer_w_we;
  assign src_rd[2]   = IS_SECOND ? w_rd : i_peer_w_rd;
  assign src_data[2] = IS_SECOND ? w_data : i_peer_w_data;
  assign src_we[3]   = IS_SECOND ? i_peer_w_we : w_rd_we;
  assign src_rd[3]   = IS_SECOND ? i_peer_w_rd : w_rd;
  assign src_data[3] = IS_SECOND ? i_peer_w_data : w_data;

  always_comb begin
    op_a = x_a;
    op_b = x_b;
    for (int i = 3; i >= 0; i--) begin  // youngest match applied last
      if (src_we[i] && src_rd[i] == x_rs) op_a = src_data[i];
      if (src_we[i] && src_rd[i] == x_rt) op_b = src_data[i];
    end
  end

  lc4_alu alu (
    .i_op(x_alu_op), .i_a(op_a), .i_b(op_b), .i_imm(x_imm), .o_result(alu_result)
  );

  assign o_x_load    = x_is_load;
  assign o_x_rd      = x_rd;
  assign o_m_we      = m_rd_we;
  assign o_m_rd      = m_rd;
  assign o_m_result  = m_result;
  assign o_w_we      = w_rd_we;
  assign o_w_rd      = w_rd;
  assign o_w_data    = w_data;
  assign o_w_stall   = w_stall;
  assign o_mem_rd    = m_is_load;
  assign o_mem_wr    = m_is_store;
  assign o_mem_addr  = m_result;
  assign o_mem_wdata = m_b;

endmodule

//--- lc4_dmem_arbiter.sv
`timescale 1ns/1ns

module lc4_dmem_arbiter (
  input  logic           i_rd_a,
  input  logic           i_wr_a,
  input  lc4_pkg::word_t i_addr_a,
  input  lc4_pkg::word_t i_wdata_a,
  input  logic           i_rd_b,
  input  logic           i_wr_b,
  input  lc4_pkg::word_t i_addr_b,
  input  lc4_pkg::word_t i_wdata_b,
  output lc4_pkg::word_t o_dmem_addr,
  output logic           o_dmem_we,
  output lc4_pkg::word_t o_dmem_wdata,
  input  lc4_pkg::word_t i_dmem_rdata,
  output lc4_pkg::word_t o_rdata_a,
  output lc4_pkg::word_t o_rdata_b
);

  logic req_a, req_b;

  assign req_a = i_rd_a || i_wr_a;
  assign req_b = i_rd_b || i_wr_b;

  // lane a has the port whenever it asks
  assign o_dmem_addr  = req_a ? i_addr_a : (req_b ? i_addr_b : '0);
  assign o_dmem_we    = req_a ? i_wr_a : i_wr_b;
  assign o_dmem_wdata = req_a ? i_wdata_a : (req_b ? i_wdata_b : '0);
  assign o_rdata_a    = i_rd_a ? i_dmem_rdata : '0;
  assign o_rdata_b    = (i_rd_b && !req_a) ? i_dmem_rdata : '0;

endmodule

//--- lc4_superscalar.sv
`timescale 1ns/1ns

module lc4_superscalar #(
  parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
  input  logic              gwe,
  input  logic              i_rst,
  output lc4_pkg::word_t    o_pc,
  input  lc4_pkg::word_t    i_insn_a,
  input  lc4_pkg::word_t    i_insn_b,
  output lc4_pkg::word_t    o_dmem_addr,
  output logic              o_dmem_we,
  output lc4_pkg::word_t    o_dmem_wdata,
  input  lc4_pkg::word_t    i_dmem_rdata,
  output logic              o_wb_we_a, o_wb_we_b,
  output lc4_pkg::reg_sel_t o_wb_wsel_a, o_wb_wsel_b,
  output lc4_pkg::word_t    o_wb_data_a, o_wb_data_b,
  output lc4_pkg::stall_t   o_wb_stall_a, o_wb_stall_b
);
  import lc4_pkg::*;

  reg_sel_t rsel_a0, rsel_a1, rsel_b0, rsel_b1;
  word_t    rdata_a0, rdata_a1, rdata_b0, rdata_b1;

  logic     issue_a, rd_we_a, is_load_a, is_store_a;
  logic     issue_b, rd_we_b, is_load_b, is_store_b;
  stall_t   stall_a, stall_b;
  reg_sel_t rd_a, rs_a, rt_a, rd_b, rs_b, rt_b;
  alu_op_t  alu_op_a, alu_op_b;
  word_t    imm_a, a_a, b_a, imm_b, a_b, b_b;

  logic     x_load_a, x_load_b, m_we_a, m_we_b;
  reg_sel_t x_rd_a, x_rd_b, m_rd_a, m_rd_b;
  word_t    m_result_a, m_result_b;

  logic     mem_rd_a, mem_wr_a, mem_rd_b, mem_wr_b;
  word_t    mem_addr_a, mem_wdata_a, mem_rdata_a;
  word_t    mem_addr_b, mem_wdata_b, mem_rdata_b;

  lc4_issue_ctrl #(.RESET_PC(RESET_PC)) issue (
    .gwe(gwe), .i_rst(i_rst), .i_insn_a(i_insn_a), .i_insn_b(i_insn_b), .o_pc(o_pc),
    .o_rsel_a0(rsel_a0), .o_rsel_a1(rsel_a1), .o_rsel_b0(rsel_b0), .o_rsel_b1(rsel_b1),
    .i_rdata_a0(rdata_a0), .i_rdata_a1(rdata_a1),
    .i_rdata_b0(rdata_b0), .i_rdata_b1(rdata_b1),
    .i_x_load_a(x_load_a), .i_x_rd_a(x_rd_a), .i_x_load_b(x_load_b), .i_x_rd_b(x_rd_b),
    .o_issue_a(issue_a), .o_stall_a(stall_a), .o_rd_a(rd_a), .o_rs_a(rs_a), .o_rt_a(rt_a),
    .o_rd_we_a(rd_we_a), .o_is_load_a(is_load_a), .o_is_store_a(is_store_a),
    .o_alu_op_a(alu_op_a), .o_imm_a(imm_a), .o_a_a(a_a), .o_b_a(b_a),
    .o_issue_b(issue_b), .o_stall_b(stall_b), .o_rd_b(rd_b), .o_rs_b(rs_b), .o_rt_b(rt_b),
    .o_rd_we_b(rd_we_b), .o_is_load_b(is_load_b), .o_is_store_b(is_store_b),
    .o_alu_op_b(alu_op_b), .o_imm_b(imm_b), .o_a_b(a_b), .o_b_b(b_b)
  );

  lc4_regfile_2w regfile (
    .gwe(gwe), .i_rst(i_rst),
    .i_rsel_a0(rsel_a0), .i_rsel_a1(rsel_a1), .i_rsel_b0(rsel_b0), .i_rsel_b1(rsel_b1),
    .i_we_a(o_wb_we_a), .i_we_b(o_wb_we_b), .i_wsel_a(o_wb_wsel_a), .i_wsel_b(o_wb_wsel_b),
    .i_wdata_a(o_wb_data_a), .i_wdata_b(o_wb_data_b),
    .o_rdata_a0(rdata_a0), .o_rdata_a1(rdata_a1),
    .o_rdata_b0(rdata_b0), .o_rdata_b1(rdata_b1)
  );

  lc4_lane #(.IS_SECOND(1'b0)) lane_a (
    .gwe(gwe), .i_rst(i_rst), .i_issue(issue_a), .i_stall(stall_a),
    .i_rd(rd_a), .i_rs(rs_a), .i_rt(rt_a),
    .i_rd_we(rd_we_a), .i_is_load(is_load_a), .i_is_store(is_store_a),
    .i_alu_op(alu_op_a), .i_imm(imm_a), .i_a(a_a), .i_b(b_a),
    .o_x_load(x_load_a), .o_x_rd(x_rd_a),
    .o_m_we(m_we_a), .o_m_rd(m_rd_a), .o_m_result(m_result_a),
    .i_peer_m_we(m_we_b), .i_peer_m_rd(m_rd_b), .i_peer_m_result(m_result_b),
    .o_w_we(o_wb_we_a), .o_w_rd(o_wb_wsel_a), .o_w_data(o_wb_data_a),
    .o_w_stall(o_wb_stall_a),
    .i_peer_w_we(o_wb_we_b), .i_peer_w_rd(o_wb_wsel_b), .i_peer_w_data(o_wb_data_b),
    .o_mem_rd(mem_rd_a), .o_mem_wr(mem_wr_a), .o_mem_addr(mem_addr_a),
    .o_mem_wdata(mem_wdata_a), .i_mem_rdata(mem_rdata_a)
  );

  lc4_lane #(.IS_SECOND(1'b1)) lane_b (
    .gwe(gwe), .i_rst(i_rst), .i_issue(issue_b), .i_stall(stall_b),
    .i_rd(rd_b), .i_rs(rs_b), .i_rt(rt_b),
    .i_rd_we(rd_we_b), .i_is_load(is_load_b), .i_is_store(is_store_b),
    .i_alu_op(alu_op_b), .i_imm(imm_b), .i_a(a_b), .i_b(b_b),
    .o_x_load(x_load_b), .o_x_rd(x_rd_b),
    .o_m_we(m_we_b), .o_m_rd(m_rd_b), .o_m_result(m_result_b),
    .i_peer_m_we(m_we_a), .i_peer_m_rd(m_rd_a), .i_peer_m_result(m_result_a),
    .o_w_we(o_wb_we_b), .o_w_rd(o_wb_wsel_b), .o_w_data(o_wb_data_b),
    .o_w_stall(o_wb_stall_b),
    .i_peer_w_we(o_wb_we_a), .i_peer_w_rd(o_wb_wsel_a), .i_peer_w_data(o_wb_data_a),
    .o_mem_rd(mem_rd_b), .o_mem_wr(mem_wr_b), .o_mem_addr(mem_addr_b),
    .o_mem_wdata(mem_wdata_b), .i_mem_rdata(mem_rdata_b)
  );

  lc4_dmem_arbiter dmem_arb (
    .i_rd_a(mem_rd_a), .i_wr_a(mem_wr_a), .i_addr_a(mem_addr_a), .i_wdata_a(mem_wdata_a),
    .i_rd_b(mem_rd_b), .i_wr_b(mem_wr_b), .i_addr_b(mem_addr_b), .i_wdata_b(mem_wdata_b),
    .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we), .o_dmem_wdata(o_dmem_wdata),
    .i_dmem_rdata(i_dmem_rdata), .o_rdata_a(mem_rdata_a), .o_rdata_b(mem_rdata_b)
  );

endmodule

//--- tb_lc4_superscalar.sv
`timescale 1ns/1ns

module tb_lc4_superscalar;
  import lc4_pkg::*;

  localparam word_t RESET_PC     = 16'h8200;
  localparam int    MAX_CYCLES   = 300;
  localparam int    DRAIN_CYCLES = 8;  // lets trailing bubbles reach W

  logic     gwe;
  logic     i_rst;
  word_t    o_pc, i_insn_a, i_insn_b;
  word_t    o_dmem_addr, o_dmem_wdata, i_dmem_rdata;
  logic     o_dmem_we;
  logic     o_wb_we_a, o_wb_we_b;
  reg_sel_t o_wb_wsel_a, o_wb_wsel_b;
  word_t    o_wb_data_a, o_wb_data_b;
  stall_t   o_wb_stall_a, o_wb_stall_b;

  word_t    imem [65536];
  word_t    dmem [65536];
  reg_sel_t exp_reg_q [$];
  word_t    exp_val_q [$];
  word_t    exp_addr_q [$];
  word_t    exp_data_q [$];
  int       exp_load_use, exp_superscalar;
  int       n_load_use, n_superscalar;
  int       cycles_since_rst;
  bit       checking;

  lc4_superscalar #(.RESET_PC(RESET_PC)) lc4_superscalar_inst (
    .gwe(gwe), .i_rst(i_rst), .o_pc(o_pc), .i_insn_a(i_insn_a), .i_insn_b(i_insn_b),
    .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we), .o_dmem_wdata(o_dmem_wdata),
    .i_dmem_rdata(i_dmem_rdata),
    .o_wb_we_a(o_wb_we_a), .o_wb_we_b(o_wb_we_b),
    .o_wb_wsel_a(o_wb_wsel_a), .o_wb_wsel_b(o_wb_wsel_b),
    .o_wb_data_a(o_wb_data_a), .o_wb_data_b(o_wb_data_b),
    .o_wb_stall_a(o_wb_stall_a), .o_wb_stall_b(o_wb_stall_b)
  );

  always #5 gwe = ~gwe;

  // both memories answer in the same cycle
  assign i_insn_a     = imem[o_pc];
  assign i_insn_b     = imem[o_pc + 16'd1];
  assign i_dmem_rdata = dmem[o_dmem_addr];

  always @(posedge gwe) begin
    if (!i_rst && o_dmem_we) dmem[o_dmem_addr] <= o_dmem_wdata;
  end

  task automatic stop_on_failure();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_reg(input string name, input reg_sel_t got, input reg_sel_t exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_stall(input string name, input stall_t got, input stall_t exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic load_testdata();
    int          fd;
    int          n;
    string       line;
    string       tag;
    logic [31:0] f1, f2;
    fd = $fopen("lc4_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open lc4_testdata.txt");
      stop_on_failure();
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#" && $sscanf(line, "%s %h %h", tag, f1, f2) == 3) begin
          if (tag == "I") imem[f1[15:0]] = f2[15:0];
          else if (tag == "D") dmem[f1[15:0]] = f2[15:0];
          else if (tag == "R") begin
            exp_reg_q.push_back(f1[2:0]);
            exp_val_q.push_back(f2[15:0]);
          end else if (tag == "S") begin
            exp_addr_q.push_back(f1[15:0]);
            exp_data_q.push_back(f2[15:0]);
          end else if (tag == "C") begin
            exp_load_use    = f1;
            exp_superscalar = f2;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_commit(input string lane, input logic we, input reg_sel_t wsel,
                              input word_t data);
    reg_sel_t exp_reg;
    word_t    exp_val;
    if (we) begin
      if (exp_reg_q.size() == 0) begin
        $display("unexpected register write on lane %s at time %0t", lane, $time);
        stop_on_failure();
      end else begin
        exp_reg = exp_reg_q.pop_front();
        exp_val = exp_val_q.pop_front();
        check_reg({"o_wb_wsel_", lane}, wsel, exp_reg);
        check_word({"o_wb_data_", lane}, data, exp_val);
      end
    end
  endtask

  task automatic check_store();
    word_t exp_addr;
    word_t exp_data;
    if (exp_addr_q.size() == 0) begin
      $display("unexpected store to address %h at time %0t", o_dmem_addr, $time);
      stop_on_failure();
    end else begin
      exp_addr = exp_addr_q.pop_front();
      exp_data = exp_data_q.pop_front();
      check_word("o_dmem_addr", o_dmem_addr, exp_addr);
      check_word("o_dmem_wdata", o_dmem_wdata, exp_data);
    end
  endtask

  // outputs are settled at the falling edge
  always @(negedge gwe) begin
    if (checking) begin
      if (cycles_since_rst == 0) check_word("o_pc", o_pc, RESET_PC);
      if (cycles_since_rst < 3) begin
        check_stall("o_wb_stall_a", o_wb_stall_a, STALL_BUBBLE);
        check_stall("o_wb_stall_b", o_wb_stall_b, STALL_BUBBLE);
        if (o_wb_we_a || o_wb_we_b || o_dmem_we) begin
          $display("write seen before the first commit at time %0t", $time);
          stop_on_failure();
        end
      end
      check_commit("a", o_wb_we_a, o_wb_wsel_a, o_wb_data_a);
      check_commit("b", o_wb_we_b, o_wb_wsel_b, o_wb_data_b);
      if (o_dmem_we) check_store();
      if (o_wb_stall_a == STALL_LOAD_USE) n_load_use++;
      if (o_wb_stall_b == STALL_LOAD_USE) n_load_use++;
      if (o_wb_stall_a == STALL_SUPERSCALAR) n_superscalar++;
      if (o_wb_stall_b == STALL_SUPERSCALAR) n_superscalar++;
      cycles_since_rst++;
    end
  end

  initial begin
    int cycles;
    gwe              = 1'b0;
    i_rst            = 1'b1;
    checking         = 1'b0;
    cycles_since_rst = 0;
    n_load_use       = 0;
    n_superscalar    = 0;
    exp_load_use     = 0;
    exp_superscalar  = 0;
    for (int i = 0; i < 65536; i++) begin
      imem[i] = '0;  // empty program space decodes as nop
      dmem[i] = '0;
    end
    load_testdata();
    repeat (3) @(posedge gwe);
    @(posedge gwe);
    i_rst    <= 1'b0;
    checking <= 1'b1;
    cycles = 0;
    while ((exp_reg_q.size() > 0 || exp_addr_q.size() > 0) && cycles < MAX_CYCLES) begin
      @(posedge gwe);
      cycles++;
    end
    if (exp_reg_q.size() > 0 || exp_addr_q.size() > 0) begin
      $display("timeout: %0d commits and %0d stores still missing after %0d cycles",
               exp_reg_q.size(), exp_addr_q.size(), cycles);
      stop_on_failure();
    end else begin
      // counts were last updated on the falling edge before this one
      repeat (DRAIN_CYCLES) @(posedge gwe);
      check_word("load-use stall count", word_t'(n_load_use), word_t'(exp_load_use));
      check_word("superscalar stall count", word_t'(n_superscalar), word_t'(exp_superscalar));
      $display("Regression passed");
      $finish;
    end
  end

endmodule

//--- lc4_testdata.txt
# I addr insn | D addr data | R reg value (commit order) | S addr data (store order)
# C load-use-count superscalar-count (small counts, read as hex)
I 8200 9220
I 8201 9405
I 8202 97FD
I 8203 1842
I 8204 1B13
I 8205 5D44
I 8206 1EE7
I 8207 6240
I 8208 6441
I 8209 1647
I 820A 1882
I 820B 7842
I 820C 7643
I 820D 6A42
I 820E 1D43
I 820F 0000
D 0020 1234
D 1235 0055
R 1 0020
R 2 0005
R 3 FFFD
R 4 0025
R 5 0028
R 6 0020
R 7 0004
R 1 1234
R 2 0055
R 3 1238
R 4 00AA
R 5 00AA
R 6 12E2
S 1236 00AA
S 1237 1238
C 3 9

//--- tb.f
lc4_pkg.sv
lc4_decoder.sv
lc4_alu.sv
lc4_regfile_2w.sv
lc4_issue_ctrl.sv
lc4_lane.sv
lc4_dmem_arbiter.sv
lc4_superscalar.sv
tb_lc4_superscalar.sv
